// File: include/pcie_msg_settings.svh
/* Widths, fragment codes, queue layout and status bit positions
   shared by the PCIe message receiver */
`ifndef PCIE_MSG_SETTINGS_SVH
`define PCIE_MSG_SETTINGS_SVH

// Bus and header widths
`define PMR_DATA_W        256
`define PMR_HDR_W         128
`define PMR_LEN_W         8
`define PMR_TAG_W         4

// Fragment buffer, beat counter and buffer index widths
`define PMR_MAX_BEATS     16
`define PMR_BEAT_W        5
`define PMR_IDX_W         4

// Queue regions in SRAM, fill offset width
`define PMR_NUM_Q         4
`define PMR_Q_BEATS       64
`define PMR_FILL_W        7
`define PMR_SRAM_AW       8

// Header encodings
`define PMR_HDR_VER       4'd1
`define PMR_FRAG_S        2'd2
`define PMR_FRAG_M        2'd0
`define PMR_FRAG_L        2'd1
`define PMR_FRAG_SG       2'd3

// Status and counters
`define PMR_CNT_W         8
`define PMR_STAT_W        32
`define PMR_INTR_DONE_BIT 0
`define PMR_INTR_ERR_BIT  3

`endif

// File: verilog/msg_hdr_pkg.sv
/* Message header word with its assembly and routing views */
`include "pcie_msg_settings.svh"

package msg_hdr_pkg;

    // Fields used for fragment assembly
    typedef struct packed {
        logic [1:0]                 frag_type;
        logic [1:0]                 pkt_sn;
        logic [`PMR_TAG_W-1:0]      msg_tag;
        logic [`PMR_HDR_W-9:0]      tlp;
    } hdr_asm_t;

    // Same word as seen by the header checks
    typedef struct packed {
        logic [1:0]                 frag_type;
        logic [1:0]                 pkt_sn;
        logic                       tag_owner;
        logic [2:0]                 tlp_tag;
        logic [19:0]                rsvd_hi;
        logic [3:0]                 version;
        logic [95:0]                rsvd_lo;
    } hdr_route_t;

    typedef union packed {
        hdr_asm_t                   asm_view;
        hdr_route_t                 route_view;
    } hdr_word_u;

endpackage

// File: verilog/msg_ifs.sv
/* Internal buses of the receiver
   frag_if carries a received fragment, asm_if the assembly verdict */
`timescale 1ns/100ps
`include "pcie_msg_settings.svh"

interface frag_if;
    logic                       frag_valid;
    msg_hdr_pkg::hdr_word_u     hdr;
    logic [`PMR_BEAT_W-1:0]     n_beats;
    logic [`PMR_IDX_W-1:0]      rd_idx;
    logic [`PMR_DATA_W-1:0]     rd_data;
    logic                       done;

    modport src (output frag_valid, hdr, n_beats, rd_data, input rd_idx, done);
    modport chk (input hdr, frag_valid);
    modport trk (input hdr, frag_valid, n_beats);
    modport cmt (input n_beats, rd_data, output rd_idx, done);
endinterface

interface asm_if;
    logic                       v_valid;
    logic                       accept;
    logic                       complete;
    logic [`PMR_FILL_W-1:0]     fill;
    logic [`PMR_TAG_W-1:0]      tag;
    logic                       orphan;
    logic                       seq_err;
    logic                       commit;

    modport trk (
        output v_valid, accept, complete, fill, tag, orphan, seq_err,
        input  commit
    );
    modport cmt (
        input  v_valid, accept, complete, fill, tag, orphan, seq_err,
        output commit
    );
endinterface

// File: verilog/axi_wr_slave.sv
/* AXI write slave with fragment beat buffer and header capture */
`timescale 1ns/100ps
`include "pcie_msg_settings.svh"

module axi_wr_slave (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    awvalid,
    input  logic [`PMR_LEN_W-1:0]   awlen,
    output logic                    awready,
    input  logic                    wvalid,
    input  logic [`PMR_DATA_W-1:0]  wdata,
    input  logic                    wlast,
    output logic                    wready,
    output logic                    bvalid,
    output logic [1:0]              bresp,
    input  logic                    bready,
    frag_if.src                     fr
);
    typedef enum logic [1:0] {PH_ADDR, PH_DATA, PH_RESP} phase_t;

    phase_t                     phase;
    logic [`PMR_IDX_W-1:0]      wr_idx;
    logic [`PMR_DATA_W-1:0]     beat_buf [`PMR_MAX_BEATS];
    logic                       w_hs;

    assign w_hs       = wvalid && wready;
    assign bresp      = 2'b00;
    assign fr.rd_data = beat_buf[fr.rd_idx];

    // Beat 0 holds the header in its upper half
    always_ff @(posedge clk) begin
        if (w_hs) begin
            beat_buf[wr_idx] <= wdata;
            if (wr_idx == '0)
                fr.hdr <= wdata[`PMR_DATA_W-1 -: `PMR_HDR_W];
        end
    end

    // =========================================================================
    // Address, data and response phases
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase         <= PH_ADDR;
            awready       <= 1'b0;
            wready        <= 1'b0;
            bvalid        <= 1'b0;
            wr_idx        <= '0;
            fr.n_beats    <= '0;
            fr.frag_valid <= 1'b0;
        end else begin
            fr.frag_valid <= 1'b0;
            case (phase)
                PH_ADDR: begin
                    if (awvalid && awready) begin
                        awready    <= 1'b0;
                        wready     <= 1'b1;
                        wr_idx     <= '0;
                        fr.n_beats <= `PMR_BEAT_W'(awlen) + 1'b1;
                        phase      <= PH_DATA;
                    end else begin
                        awready <= 1'b1;
                    end
                end
                PH_DATA: begin
                    if (w_hs) begin
                        wr_idx <= wr_idx + 1'b1;
                        if (wlast) begin
                            wready        <= 1'b0;
                            fr.frag_valid <= 1'b1;
                            phase         <= PH_RESP;
                        end
                    end
                end
                PH_RESP: begin
                    // Answer only after the committer has released the buffer
                    if (fr.done)
                        bvalid <= 1'b1;
                    if (bvalid && bready) begin
                        bvalid  <= 1'b0;
                        awready <= 1'b1;
                        phase   <= PH_ADDR;
                    end
                end
                default: phase <= PH_ADDR;
            endcase
        end
    end

endmodule

// File: verilog/hdr_checker.sv
/* Header version and tag owner checks with their error counters */
`timescale 1ns/100ps
`include "pcie_msg_settings.svh"

module hdr_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    frag_if.chk                     fr,
    output logic                    hdr_ok,
    output logic                    chk_valid,
    output logic [`PMR_CNT_W-1:0]   err_ver_cnt,
    output logic [`PMR_CNT_W-1:0]   err_to_cnt
);
    msg_hdr_pkg::hdr_route_t    rt;
    logic                       ver_bad;
    logic                       to_bad;

    assign rt      = fr.hdr.route_view;
    assign ver_bad = rt.version != `PMR_HDR_VER;
    // Tag 7 needs the owner bit set
    assign to_bad  = (rt.tlp_tag == 3'd7) && !rt.tag_owner;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_ok      <= 1'b0;
            chk_valid   <= 1'b0;
            err_ver_cnt <= '0;
            err_to_cnt  <= '0;
        end else begin
            chk_valid <= fr.frag_valid;
            if (fr.frag_valid) begin
                // Owner error is counted only, fragment still goes through
                hdr_ok <= !ver_bad;
                if (ver_bad)
                    err_ver_cnt <= err_ver_cnt + 1'b1;
                if (to_bad)
                    err_to_cnt <= err_to_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/frag_tracker.sv
/* Per-tag assembly state and sequence verdict for each fragment */
`timescale 1ns/100ps
`include "pcie_msg_settings.svh"

module frag_tracker (
    input  logic                clk,
    input  logic                rst_n,
    frag_if.trk                 fr,
    asm_if.trk                  va
);
    localparam int QW = $clog2(`PMR_NUM_Q);

    logic                       q_active [`PMR_NUM_Q];
    logic [1:0]                 q_exp_sn [`PMR_NUM_Q];
    logic [`PMR_FILL_W-1:0]     q_fill   [`PMR_NUM_Q];

    msg_hdr_pkg::hdr_asm_t      h;
    logic                       in_range;
    logic [QW-1:0]              idx;
    logic [QW-1:0]              cidx;
    logic [`PMR_FILL_W-1:0]     pay;
    logic                       c_accept;
    logic                       c_complete;
    logic                       c_orphan;
    logic                       c_seq_err;
    logic [`PMR_FILL_W-1:0]     c_fill;

    assign h        = fr.hdr.asm_view;
    assign in_range = h.msg_tag < `PMR_NUM_Q;
    assign idx      = h.msg_tag[QW-1:0];
    assign cidx     = va.tag[QW-1:0];
    assign pay      = `PMR_FILL_W'(fr.n_beats) - 1'b1;

    // Verdict for the fragment on the bus
    always_comb begin
        c_accept   = 1'b0;
        c_complete = 1'b0;
        c_orphan   = 1'b0;
        c_seq_err  = 1'b0;
        c_fill     = '0;
        if (in_range) begin
            case (h.frag_type)
                `PMR_FRAG_SG: begin
                    c_accept   = 1'b1;
                    c_complete = 1'b1;
                end
                `PMR_FRAG_S: c_accept = (h.pkt_sn == 2'd0);
                default: begin
                    if (!q_active[idx]) begin
                        c_orphan = 1'b1;
                    end else if (h.pkt_sn != q_exp_sn[idx]) begin
                        c_seq_err = 1'b1;
                    end else begin
                        c_accept   = 1'b1;
                        c_complete = (h.frag_type == `PMR_FRAG_L);
                        c_fill     = q_fill[idx];
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            va.v_valid  <= 1'b0;
            va.accept   <= 1'b0;
            va.complete <= 1'b0;
            va.orphan   <= 1'b0;
            va.seq_err  <= 1'b0;
            va.fill     <= '0;
            va.tag      <= '0;
        end else begin
            va.v_valid <= fr.frag_valid;
            if (fr.frag_valid) begin
                va.accept   <= c_accept;
                va.complete <= c_complete;
                va.orphan   <= c_orphan;
                va.seq_err  <= c_seq_err;
                va.fill     <= c_fill;
                va.tag      <= h.msg_tag;
            end
        end
    end

    // Queue state moves only when the committer takes the fragment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < `PMR_NUM_Q; q++) begin
                q_active[q] <= 1'b0;
                q_exp_sn[q] <= '0;
                q_fill[q]   <= '0;
            end
        end else if (va.commit) begin
            case (h.frag_type)
                `PMR_FRAG_S: begin
                    q_active[cidx] <= 1'b1;
                    q_exp_sn[cidx] <= 2'd1;
                    q_fill[cidx]   <= pay;
                end
                `PMR_FRAG_M: begin
                    q_exp_sn[cidx] <= q_exp_sn[cidx] + 1'b1;
                    q_fill[cidx]   <= q_fill[cidx] + pay;
                end
                `PMR_FRAG_L: q_active[cidx] <= 1'b0;
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/msg_committer.sv
/* Commit decision, payload writes to SRAM, completion status,
   write pointer and assembly error counters */
`timescale 1ns/100ps
`include "pcie_msg_settings.svh"

module msg_committer (
    input  logic                    clk,
    input  logic                    rst_n,
    frag_if.cmt                     fr,
    asm_if.cmt                      va,
    input  logic                    hdr_ok,
    input  logic                    chk_valid,
    output logic                    sram_wen,
    output logic [`PMR_SRAM_AW-1:0] sram_waddr,
    output logic [`PMR_DATA_W-1:0]  sram_wdata,
    output logic [`PMR_STAT_W-1:0]  intr_status,
    input  logic [`PMR_STAT_W-1:0]  intr_clear,
    output logic [`PMR_STAT_W-1:0]  data_wptr,
    output logic                    msg_interrupt,
    output logic                    assembled_valid,
    output logic [`PMR_TAG_W-1:0]   assembled_tag,
    output logic [`PMR_CNT_W-1:0]   err_orphan_cnt,
    output logic [`PMR_CNT_W-1:0]   err_seq_cnt
);
    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_UPDATE, ST_DONE} state_t;

    state_t                     state;
    logic                       verdict;
    logic                       last_beat;
    logic [`PMR_IDX_W-1:0]      beat_k;
    logic [`PMR_SRAM_AW-1:0]    wr_addr;
    logic [`PMR_FILL_W-1:0]     total;
    logic [`PMR_TAG_W-1:0]      c_tag;
    logic                       c_complete;
    logic [`PMR_STAT_W-1:0]     set_vec;

    assign verdict       = va.v_valid && chk_valid;
    assign va.commit     = verdict && hdr_ok && va.accept;
    assign last_beat     = (`PMR_BEAT_W'(beat_k) + 1'b1) == fr.n_beats;
    assign fr.rd_idx     = beat_k;
    assign fr.done       = (state == ST_DONE);
    assign sram_wen      = (state == ST_WRITE);
    assign sram_waddr    = wr_addr;
    assign sram_wdata    = fr.rd_data;
    assign msg_interrupt = |intr_status;

    always_comb begin
        set_vec = '0;
        set_vec[`PMR_INTR_DONE_BIT] = (state == ST_UPDATE) && c_complete;
        set_vec[`PMR_INTR_ERR_BIT]  = verdict && !hdr_ok;
    end

    // =========================================================================
    // Payload write sequence
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            beat_k          <= '0;
            wr_addr         <= '0;
            total           <= '0;
            c_tag           <= '0;
            c_complete      <= 1'b0;
            data_wptr       <= '0;
            assembled_valid <= 1'b0;
            assembled_tag   <= '0;
        end else begin
            assembled_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (va.commit) begin
                        // Region base is tag times region size
                        beat_k     <= `PMR_IDX_W'(1);
                        wr_addr    <= `PMR_SRAM_AW'(va.tag) * `PMR_SRAM_AW'(`PMR_Q_BEATS)
                                      + `PMR_SRAM_AW'(va.fill);
                        total      <= va.fill + `PMR_FILL_W'(fr.n_beats) - 1'b1;
                        c_tag      <= va.tag;
                        c_complete <= va.complete;
                        state      <= (fr.n_beats > 1) ? ST_WRITE : ST_UPDATE;
                    end else if (verdict) begin
                        state <= ST_DONE;
                    end
                end
                ST_WRITE: begin
                    beat_k  <= beat_k + 1'b1;
                    wr_addr <= wr_addr + 1'b1;
                    if (last_beat)
                        state <= ST_UPDATE;
                end
                ST_UPDATE: begin
                    if (c_complete) begin
                        data_wptr       <= `PMR_STAT_W'(total) * (`PMR_DATA_W / 8);
                        assembled_valid <= 1'b1;
                        assembled_tag   <= c_tag;
                    end
                    state <= ST_DONE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Status bits, clear wins over set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            intr_status    <= '0;
            err_orphan_cnt <= '0;
            err_seq_cnt    <= '0;
        end else begin
            intr_status <= (intr_status | set_vec) & ~intr_clear;
            if (verdict && hdr_ok && va.orphan)
                err_orphan_cnt <= err_orphan_cnt + 1'b1;
            if (verdict && hdr_ok && va.seq_err)
                err_seq_cnt <= err_seq_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/pcie_msg_rx.sv
/* PCIe message receiver top level
   AXI slave, header checker, fragment tracker and committer */
`timescale 1ns/100ps
`include "pcie_msg_settings.svh"

module pcie_msg_rx (
    input  logic                    clk,
    input  logic                    rst_n,

    // AXI write channels
    input  logic                    awvalid,
    input  logic [`PMR_LEN_W-1:0]   awlen,
    output logic                    awready,
    input  logic                    wvalid,
    input  logic [`PMR_DATA_W-1:0]  wdata,
    input  logic                    wlast,
    output logic                    wready,
    output logic                    bvalid,
    output logic [1:0]              bresp,
    input  logic                    bready,

    // SRAM write port
    output logic                    sram_wen,
    output logic [`PMR_SRAM_AW-1:0] sram_waddr,
    output logic [`PMR_DATA_W-1:0]  sram_wdata,

    // Status, pointer and counters
    output logic [`PMR_STAT_W-1:0]  intr_status,
    input  logic [`PMR_STAT_W-1:0]  intr_clear,
    output logic [`PMR_STAT_W-1:0]  data_wptr,
    output logic                    msg_interrupt,
    output logic                    assembled_valid,
    output logic [`PMR_TAG_W-1:0]   assembled_tag,
    output logic [`PMR_CNT_W-1:0]   err_ver_cnt,
    output logic [`PMR_CNT_W-1:0]   err_to_cnt,
    output logic [`PMR_CNT_W-1:0]   err_orphan_cnt,
    output logic [`PMR_CNT_W-1:0]   err_seq_cnt
);
    frag_if     fr_bus ();
    asm_if      va_bus ();
    logic       hdr_ok;
    logic       chk_valid;

    axi_wr_slave  u_axi (.*, .fr(fr_bus));
    hdr_checker   u_chk (.*, .fr(fr_bus));
    frag_tracker  u_trk (.*, .fr(fr_bus), .va(va_bus));
    msg_committer u_cmt (.*, .fr(fr_bus), .va(va_bus));

endmodule

// File: bench/pcie_msg_rx_asserts.sv
/* Concurrent protocol assertions for the receiver top level,
   bound into pcie_msg_rx from the testbench */
`timescale 1ns/100ps

module pcie_msg_rx_asserts (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        awready,
    input  logic        bvalid,
    input  logic        bready,
    input  logic        sram_wen,
    input  logic        wready
);
    int fail_cnt = 0;

    // B channel holds its response until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_cnt++;
        end

    // No new address while a response is pending
    a_aw_vs_b: assert property (@(posedge clk) disable iff (!rst_n)
        !(awready && bvalid))
        else begin
            $error("awready high together with bvalid");
            fail_cnt++;
        end

    a_wen_vs_w: assert property (@(posedge clk) disable iff (!rst_n)
        !(sram_wen && wready))
        else begin
            $error("SRAM write while W channel is open");
            fail_cnt++;
        end

endmodule

// File: bench/pcie_msg_rx_tb.sv
/* Testbench for the PCIe message receiver with fragment table,
   AXI stimulus loop, SRAM write monitor, checks and timeout */
`timescale 1ns/100ps
`include "pcie_msg_settings.svh"

module pcie_msg_rx_tb;

    typedef struct packed {
        logic [1:0]     ft;
        logic [1:0]     sn;
        logic [3:0]     tag;
        logic [3:0]     ver;
        logic [4:0]     beats;
        logic [3:0]     dly;
        logic [31:0]    clr;
        logic           wr;
        logic [7:0]     base;
        logic           cmp;
        logic [31:0]    status;
        logic [31:0]    wptr;
        logic [31:0]    cnts;
    } frag_row_t;

    logic           clk;
    logic           rst_n;
    logic           awvalid;
    logic [7:0]     awlen;
    logic           awready;
    logic           wvalid;
    logic [255:0]   wdata;
    logic           wlast;
    logic           wready;
    logic           bvalid;
    logic [1:0]     bresp;
    logic           bready;
    logic           sram_wen;
    logic [7:0]     sram_waddr;
    logic [255:0]   sram_wdata;
    logic [31:0]    intr_status;
    logic [31:0]    intr_clear;
    logic [31:0]    data_wptr;
    logic           msg_interrupt;
    logic           assembled_valid;
    logic [3:0]     assembled_tag;
    logic [7:0]     err_ver_cnt;
    logic [7:0]     err_to_cnt;
    logic [7:0]     err_orphan_cnt;
    logic [7:0]     err_seq_cnt;

    frag_row_t      rows[$];
    string          names[$];
    string          cur_name = "reset";
    logic [7:0]     exp_addr[$];
    logic [255:0]   exp_data[$];
    logic           asm_seen;
    logic [3:0]     asm_tag;
    int             cycles = 0;
    int             limit = 1000;

    pcie_msg_rx dut_i (.*);

    bind pcie_msg_rx pcie_msg_rx_asserts asserts_i (
        .clk(clk), .rst_n(rst_n), .awready(awready), .bvalid(bvalid),
        .bready(bready), .sram_wen(sram_wen), .wready(wready)
    );

    always #20 clk = ~clk;

    task automatic check_eq(input string field, input logic [255:0] exp,
                            input logic [255:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %0h, actual %0h", cur_name, field, exp, act);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [255:0] rand_word();
        logic [255:0] w;
        for (int i = 0; i < 8; i++)
            w = {w[223:0], $urandom()};
        return w;
    endfunction

    // cnts packs the ver, tag owner, orphan and seq counters in one byte each
    task automatic add_row(input string name, input logic [1:0] ft, input logic [1:0] sn,
                           input logic [3:0] tag, input logic [3:0] ver,
                           input logic [4:0] beats, input logic [3:0] dly,
                           input logic [31:0] clr, input logic wr, input logic [7:0] base,
                           input logic cmp, input logic [31:0] st,
                           input logic [31:0] wptr, input logic [31:0] cnts);
        rows.push_back({ft, sn, tag, ver, beats, dly, clr, wr, base, cmp, st, wptr, cnts});
        names.push_back(name);
    endtask

    // ========================================================================
    // Fragment table
    // name, type, sn, tag, ver, beats, bready delay, clear mask,
    // written, base, complete, status, wptr, counters
    // ========================================================================
    task automatic load_table();
        add_row("single_t2", `PMR_FRAG_SG, 0, 2, 1, 4, 0, 1, 1, 128, 1, 1, 96, 32'h00000000);
        add_row("start_t1",  `PMR_FRAG_S,  0, 1, 1, 3, 1, 0, 1, 64,  0, 0, 96, 32'h00000000);
        add_row("middle_t1", `PMR_FRAG_M,  1, 1, 1, 2, 0, 0, 1, 66,  0, 0, 96, 32'h00000000);
        add_row("last_t1",   `PMR_FRAG_L,  2, 1, 1, 3, 0, 1, 1, 67,  1, 1, 160, 32'h00000000);
        add_row("bad_ver",   `PMR_FRAG_SG, 0, 0, 2, 3, 0, 0, 0, 0,   0, 8, 160, 32'h01000000);
        add_row("orphan_m",  `PMR_FRAG_M,  1, 3, 1, 2, 0, 0, 0, 0,   0, 8, 160, 32'h01000100);
        add_row("start_t0",  `PMR_FRAG_S,  0, 0, 1, 2, 0, 0, 1, 0,   0, 8, 160, 32'h01000100);
        add_row("seq_bad_l", `PMR_FRAG_L,  3, 0, 1, 3, 0, 0, 0, 0,   0, 8, 160, 32'h01000101);
        add_row("last_t0",   `PMR_FRAG_L,  1, 0, 1, 3, 6, 1, 1, 1,   1, 9, 96, 32'h01000101);
        // Tag 7 with owner clear lies outside the four queues
        add_row("tag_owner", `PMR_FRAG_SG, 0, 7, 1, 3, 0, 8, 0, 0,   0, 8, 96, 32'h01010101);
    endtask

    // SRAM write monitor and completion capture
    always @(posedge clk) begin
        if (rst_n && sram_wen) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected SRAM write at address %0d", sram_waddr);
                $display(">>> FAIL");
                $fatal(1, "unexpected SRAM write");
            end else begin
                check_eq("sram addr", exp_addr.pop_front(), sram_waddr);
                check_eq("sram data", exp_data.pop_front(), sram_wdata);
            end
        end
        if (rst_n && assembled_valid) begin
            asm_seen = 1'b1;
            asm_tag  = assembled_tag;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end else if (dut_i.asserts_i.fail_cnt != 0) begin
            $display("a protocol assertion failed");
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end
    end

    task automatic run_frag(input int i);
        frag_row_t      r;
        logic [255:0]   beat [16];
        logic [127:0]   hdr;
        r        = rows[i];
        cur_name = names[i];
        hdr      = {$urandom(), $urandom(), $urandom(), $urandom()};
        hdr[127:126] = r.ft;
        hdr[125:124] = r.sn;
        hdr[123:120] = r.tag;
        hdr[99:96]   = r.ver;
        for (int b = 0; b < r.beats; b++)
            beat[b] = rand_word();
        beat[0][255:128] = hdr;
        // Payload beat k lands at base plus k minus 1
        if (r.wr) begin
            for (int k = 1; k < r.beats; k++) begin
                exp_addr.push_back(r.base + k - 1);
                exp_data.push_back(beat[k]);
            end
        end
        asm_seen = 1'b0;

        @(posedge clk);
        awvalid <= 1'b1;
        awlen   <= r.beats - 1;
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
        for (int b = 0; b < r.beats; b++) begin
            wvalid <= 1'b1;
            wdata  <= beat[b];
            wlast  <= (b == r.beats - 1);
            do @(posedge clk); while (!wready);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;

        do @(posedge clk); while (!bvalid);
        check_eq("bresp", 2'b00, bresp);
        repeat (r.dly) begin
            check_eq("bvalid held", 1'b1, bvalid);
            check_eq("awready low", 1'b0, awready);
            @(posedge clk);
        end
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;

        check_eq("writes left", 0, exp_addr.size());
        check_eq("status", r.status, intr_status);
        check_eq("interrupt", |r.status, msg_interrupt);
        check_eq("wptr", r.wptr, data_wptr);
        check_eq("err_ver_cnt", r.cnts[31:24], err_ver_cnt);
        check_eq("err_to_cnt", r.cnts[23:16], err_to_cnt);
        check_eq("err_orphan_cnt", r.cnts[15:8], err_orphan_cnt);
        check_eq("err_seq_cnt", r.cnts[7:0], err_seq_cnt);
        check_eq("assembled", r.cmp, asm_seen);
        if (r.cmp)
            check_eq("assembled tag", r.tag, asm_tag);

        // Write one to clear
        if (r.clr != 0) begin
            intr_clear <= r.clr;
            @(posedge clk);
            intr_clear <= '0;
            @(posedge clk);
            check_eq("status cleared", r.status & ~r.clr, intr_status);
            check_eq("interrupt cleared", |(r.status & ~r.clr), msg_interrupt);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        awvalid    = 1'b0;
        awlen      = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wlast      = 1'b0;
        bready     = 1'b0;
        intr_clear = '0;
        void'($urandom(32'h0b96_006e));
        load_table();
        limit = 16;
        foreach (rows[i])
            limit += 2 * rows[i].beats + 12 + rows[i].dly;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_eq("status after reset", 0, intr_status);
        check_eq("wptr after reset", 0, data_wptr);

        foreach (rows[i])
            run_frag(i);

        if (dut_i.asserts_i.fail_cnt != 0) begin
            $display("protocol assertions failed during the run");
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+include
verilog/msg_hdr_pkg.sv
verilog/msg_ifs.sv
verilog/axi_wr_slave.sv
verilog/hdr_checker.sv
verilog/frag_tracker.sv
verilog/msg_committer.sv
verilog/pcie_msg_rx.sv
bench/pcie_msg_rx_asserts.sv
bench/pcie_msg_rx_tb.sv
